//--- all.f
common/st_map_pkg.sv
common/ss_map_pkg.sv
source/st_decode.sv
source/ss_decode.sv
cdc/cdc_regs.sv
cdc/cdc_fifo.sv
source/read_mux.sv
source/ss_bridge_top.sv
test/ss_bridge_checker.sv
test/tb_ss_bridge.sv

//--- cdc/cdc_fifo.sv
////////////////////
// Depth 2**FIFO_AW, full is reported apart from usedw
// Head is valid only while not empty
////////////////////
module cdc_fifo #(
	parameter int FIFO_AW = 6
) (
	input  logic               mclk,
	input  logic               ST_ALE,
	input  logic               fifo_dir,
	input  logic               fifo_clr,
	input  st_map_pkg::st_op_e st_op,
	input  logic [15:0]        st_wdata,
	input  ss_map_pkg::ss_op_e ss_op,
	input  logic [15:0]        ss_wdata,
	output logic [15:0]        fifo_head,
	output logic [FIFO_AW-1:0] fifo_usedw,
	output logic               fifo_full,
	output logic               fifo_empty,
	output logic [15:0]        rcnt
);
	import st_map_pkg::*;
	import ss_map_pkg::*;

	localparam int DEPTH = 1 << FIFO_AW;

	logic [15:0]      mem [DEPTH];
	logic [FIFO_AW:0] wr_ptr;
	logic [FIFO_AW:0] rd_ptr;
	logic [FIFO_AW:0] count;
	logic [15:0]      wr_word;
	logic             wr_en;
	logic             rd_en;

	// Direction 0: st pushes, console pops. Direction 1 the reverse
	assign wr_en = !fifo_full
		&& (fifo_dir ? (ss_op == SS_OP_FIFO_WR) : (st_op == ST_OP_FIFO_WR));
	assign rd_en = !fifo_empty
		&& (fifo_dir ? (st_op == ST_OP_FIFO_RD) : (ss_op == SS_OP_FIFO_RD));
	assign wr_word = fifo_dir ? byte_swap(ss_wdata) : st_wdata;

	// Extra pointer bit tells full from empty
	assign count      = wr_ptr - rd_ptr;
	assign fifo_usedw = count[FIFO_AW-1:0];
	assign fifo_full  = count[FIFO_AW];
	assign fifo_empty = (count == '0);
	// Show-ahead
	assign fifo_head  = mem[rd_ptr[FIFO_AW-1:0]];

	always_ff @(posedge mclk)
	begin
		if (wr_en)
			mem[wr_ptr[FIFO_AW-1:0]] <= wr_word;
	end

	always_ff @(posedge mclk or posedge ST_ALE)
	begin
		if (ST_ALE)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			rcnt   <= '0;
		end
		else
		begin
			if (fifo_clr)
			begin
				wr_ptr <= '0;
				rd_ptr <= '0;
			end
			else
			begin
				if (wr_en)
					wr_ptr <= wr_ptr + 1'b1;
				if (rd_en)
					rd_ptr <= rd_ptr + 1'b1;
			end
			// counts every console FIFO read, empty or not
			if (st_op == ST_OP_RCNT_CLR)
				rcnt <= '0;
			else if (ss_op == SS_OP_FIFO_RD)
				rcnt <= rcnt + 1'b1;
		end
	end

endmodule

//--- cdc/cdc_regs.sv
////////////////////
// HIRQ priority when both sides hit it: st set, st clear, ss AND
////////////////////
module cdc_regs (
	input  logic               mclk,
	input  logic               ST_ALE,
	input  st_map_pkg::st_op_e st_op,
	input  logic [1:0]         st_idx,
	input  logic [15:0]        st_wdata,
	input  ss_map_pkg::ss_op_e ss_op,
	input  logic [1:0]         ss_idx,
	input  logic [15:0]        ss_wdata,
	input  logic               fifo_empty,
	output logic [15:0]        st_ctrl,
	output logic [15:0]        st_stat,
	output logic [15:0]        ss_ctrl,
	output logic [15:0]        ss_cmd,
	output logic [15:0]        ss_data,
	output logic [15:0]        hirq,
	output logic [15:0]        hirq_mask,
	output logic [3:0][15:0]   cr,
	output logic [3:0][15:0]   resp,
	output logic               fifo_dir,
	output logic               fifo_clr,
	output logic               st_irq,
	output logic               ss_irq
);
	import st_map_pkg::*;
	import ss_map_pkg::*;

	logic flag_cdc;
	logic flag_cmd;
	logic flag_fifo;
	logic fifo_empty_d;
	logic fifo_drained;
	logic ack;

	assign ack          = (st_op == ST_OP_IRQ_ACK);
	// FIFO just went empty
	assign fifo_drained = fifo_empty && !fifo_empty_d;

	assign fifo_dir = st_ctrl[CTRL_FIFO_DIR];
	// Held clear for as long as the bit stays set
	assign fifo_clr = st_ctrl[CTRL_FIFO_RST];

	////////////////////
	// Interrupt flags
	////////////////////
	// Set beats a same-cycle ack
	always_ff @(posedge mclk or posedge ST_ALE)
	begin
		if (ST_ALE)
		begin
			flag_cdc     <= 1'b0;
			flag_cmd     <= 1'b0;
			flag_fifo    <= 1'b0;
			fifo_empty_d <= 1'b1;
		end
		else
		begin
			fifo_empty_d <= fifo_empty;
			// Console wrote CR4, command complete
			if (ss_op == SS_OP_CR_WR && ss_idx == 2'd3)
				flag_cdc <= 1'b1;
			else if (ack)
				flag_cdc <= flag_cdc & ~st_wdata[CTRL_CDC_EN];
			if (ss_op == SS_OP_CMD_WR)
				flag_cmd <= 1'b1;
			else if (ack)
				flag_cmd <= flag_cmd & ~st_wdata[CTRL_CMD_EN];
			if (fifo_drained)
				flag_fifo <= 1'b1;
			else if (ack)
				flag_fifo <= flag_fifo & ~st_wdata[CTRL_FIFO_EN];
		end
	end

	assign st_stat = {1'b0, st_irq, 11'd0, flag_fifo, flag_cmd, flag_cdc};
	assign st_irq  = |(st_ctrl[2:0] & {flag_fifo, flag_cmd, flag_cdc});
	assign ss_irq  = |(hirq & hirq_mask);

	////////////////////
	// Control registers
	////////////////////
	always_ff @(posedge mclk or posedge ST_ALE)
	begin
		if (ST_ALE)
		begin
			st_ctrl   <= '0;
			ss_ctrl   <= SS_CTRL_RESET;
			ss_cmd    <= '0;
			ss_data   <= '0;
			hirq      <= '0;
			hirq_mask <= '0;
		end
		else
		begin
			if (st_op == ST_OP_CTRL_WR)
				st_ctrl <= st_wdata;
			if (ss_op == SS_OP_CTRL_WR)
				ss_ctrl <= ss_wdata;
			if (ss_op == SS_OP_MASK_WR)
				hirq_mask <= ss_wdata;
			// Mailbox, st clear wins over a console write
			if (st_op == ST_OP_CMD_CLR)
				ss_cmd <= '0;
			else if (ss_op == SS_OP_CMD_WR)
				ss_cmd <= ss_wdata;
			// Data word, console wins
			if (ss_op == SS_OP_DATA_WR)
				ss_data <= ss_wdata;
			else if (st_op == ST_OP_DATA_WR)
				ss_data <= st_wdata;
			if (st_op == ST_OP_HIRQ_SET)
				hirq <= hirq | st_wdata;
			else if (st_op == ST_OP_HIRQ_CLR)
				hirq <= hirq & ~st_wdata;
			else if (ss_op == SS_OP_HIRQ_AND)
				hirq <= hirq & ss_wdata;
		end
	end

	// Command and response words
	always_ff @(posedge mclk)
	begin
		if (ss_op == SS_OP_CR_WR)
			cr[ss_idx] <= ss_wdata;
		if (st_op == ST_OP_RESP_WR)
			resp[st_idx] <= st_wdata;
	end

endmodule

//--- common/ss_map_pkg.sv
////////////////////
// Console A-bus window, region in address bits 14..12
// Word offsets in bits 5..2, half-words in bits 5..1
////////////////////
package ss_map_pkg;

	// Regions
	localparam logic [2:0] SS_RGN_CDC = 3'b000;
	localparam logic [2:0] SS_RGN_REG = 3'b111;

	////////////////////
	// CDC word offsets
	////////////////////
	localparam logic [3:0] SS_CDC_FIFO = 4'd0;
	localparam logic [3:0] SS_CDC_HIRQ = 4'd2;
	localparam logic [3:0] SS_CDC_MASK = 4'd3;
	localparam logic [3:0] SS_CDC_CR1  = 4'd6;
	localparam logic [3:0] SS_CDC_CR2  = 4'd7;
	localparam logic [3:0] SS_CDC_CR3  = 4'd8;
	localparam logic [3:0] SS_CDC_CR4  = 4'd9;

	////////////////////
	// REG offsets
	////////////////////
	// ID and version are half-words inside word 0
	localparam logic [4:0] SS_REG_ID    = 5'd0;
	localparam logic [4:0] SS_REG_VER   = 5'd1;
	localparam logic [3:0] SS_REG_CTRL  = 4'd1;
	localparam logic [3:0] SS_REG_FSTAT = 4'd2;
	localparam logic [3:0] SS_REG_CMD   = 4'd4;
	localparam logic [3:0] SS_REG_DATA  = 4'd5;
	localparam logic [3:0] SS_REG_FIFO  = 4'd6;

	// Console ctrl after reset
	localparam logic [15:0] SS_CTRL_RESET = 16'h0100;

	typedef enum logic [3:0] {
		SS_OP_NONE, SS_OP_READ, SS_OP_CTRL_WR, SS_OP_HIRQ_AND, SS_OP_MASK_WR,
		SS_OP_CR_WR, SS_OP_CMD_WR, SS_OP_DATA_WR, SS_OP_FIFO_WR, SS_OP_FIFO_RD
	} ss_op_e;

	// Console is big endian, FIFO words are stored little endian
	function automatic logic [15:0] byte_swap(input logic [15:0] w);
		return {w[7:0], w[15:8]};
	endfunction

endpackage

//--- common/st_map_pkg.sv
////////////////////
// Microcontroller register map, byte offsets on a 16-bit port
// Odd offsets are never decoded
////////////////////
package st_map_pkg;

	// Identity words, also seen from the console side
	localparam logic [15:0] ST_ID_WORD  = 16'h5253;
	localparam logic [15:0] ST_VER_WORD = 16'h1205;

	////////////////////
	// Offsets
	////////////////////
	localparam logic [7:0] ST_OFF_ID       = 8'h00;
	localparam logic [7:0] ST_OFF_VER      = 8'h02;
	localparam logic [7:0] ST_OFF_CTRL     = 8'h04;
	localparam logic [7:0] ST_OFF_STAT     = 8'h06;
	localparam logic [7:0] ST_OFF_FIFO     = 8'h08;
	localparam logic [7:0] ST_OFF_FSTAT    = 8'h0c;
	localparam logic [7:0] ST_OFF_RCNT     = 8'h0e;
	localparam logic [7:0] ST_OFF_SS_CMD   = 8'h10;
	localparam logic [7:0] ST_OFF_SS_DATA  = 8'h12;
	localparam logic [7:0] ST_OFF_SS_CTRL  = 8'h14;
	// CR1..CR4, read only here
	localparam logic [7:0] ST_OFF_CR1      = 8'h18;
	localparam logic [7:0] ST_OFF_CR2      = 8'h1a;
	localparam logic [7:0] ST_OFF_CR3      = 8'h1c;
	localparam logic [7:0] ST_OFF_CR4      = 8'h1e;
	// Responses, console reads them at the CR slots
	localparam logic [7:0] ST_OFF_RESP1    = 8'h20;
	localparam logic [7:0] ST_OFF_RESP2    = 8'h22;
	localparam logic [7:0] ST_OFF_RESP3    = 8'h24;
	localparam logic [7:0] ST_OFF_RESP4    = 8'h26;
	localparam logic [7:0] ST_OFF_HIRQ     = 8'h28;
	localparam logic [7:0] ST_OFF_MASK     = 8'h2a;
	localparam logic [7:0] ST_OFF_HIRQ_CLR = 8'h2c;

	// Ctrl bits, flag enables share positions with status and ack
	localparam int CTRL_CDC_EN   = 0;
	localparam int CTRL_CMD_EN   = 1;
	localparam int CTRL_FIFO_EN  = 2;
	localparam int CTRL_FIFO_RST = 8;
	// 1 = console to microcontroller
	localparam int CTRL_FIFO_DIR = 9;

	typedef enum logic [3:0] {
		ST_OP_NONE, ST_OP_READ, ST_OP_CTRL_WR, ST_OP_IRQ_ACK,
		ST_OP_FIFO_WR, ST_OP_FIFO_RD, ST_OP_RCNT_CLR, ST_OP_CMD_CLR,
		ST_OP_DATA_WR, ST_OP_RESP_WR, ST_OP_HIRQ_SET, ST_OP_HIRQ_CLR
	} st_op_e;

endpackage

//--- source/read_mux.sv
////////////////////
// Read word sampled in the request cycle, valid the next cycle
////////////////////
module read_mux #(
	parameter int FIFO_AW = 6
) (
	input  logic               mclk,
	input  logic               ST_ALE,
	input  st_map_pkg::st_op_e st_op,
	input  logic [7:0]         st_addr,
	input  ss_map_pkg::ss_op_e ss_op,
	input  logic [14:1]        ss_addr,
	input  logic [15:0]        st_ctrl,
	input  logic [15:0]        st_stat,
	input  logic [15:0]        ss_ctrl,
	input  logic [15:0]        ss_cmd,
	input  logic [15:0]        ss_data,
	input  logic [15:0]        hirq,
	input  logic [15:0]        hirq_mask,
	input  logic [3:0][15:0]   cr,
	input  logic [3:0][15:0]   resp,
	input  logic [15:0]        fifo_head,
	input  logic [FIFO_AW-1:0] fifo_usedw,
	input  logic               fifo_full,
	input  logic [15:0]        rcnt,
	output logic [15:0]        st_rdata,
	output logic               st_rvalid,
	output logic [15:0]        ss_rdata,
	output logic               ss_rvalid
);
	import st_map_pkg::*;
	import ss_map_pkg::*;

	logic        st_rd;
	logic        ss_rd;
	logic [15:0] fifo_stat;
	logic [15:0] st_word;
	logic [15:0] ss_word;
	logic [2:0]  ss_rgn;
	logic [3:0]  ss_woff;
	logic [4:0]  ss_hoff;
	logic [3:0]  ss_cr_off;

	assign st_rd     = (st_op == ST_OP_READ) || (st_op == ST_OP_FIFO_RD);
	assign ss_rd     = (ss_op == SS_OP_READ) || (ss_op == SS_OP_FIFO_RD);
	assign fifo_stat = 16'({fifo_full, fifo_usedw});
	assign ss_rgn    = ss_addr[14:12];
	assign ss_woff   = ss_addr[5:2];
	assign ss_hoff   = ss_addr[5:1];
	assign ss_cr_off = ss_woff - SS_CDC_CR1;

	////////////////////
	// st view
	////////////////////
	always_comb
	begin
		case (st_addr)
			ST_OFF_ID:      st_word = ST_ID_WORD;
			ST_OFF_VER:     st_word = ST_VER_WORD;
			ST_OFF_CTRL:    st_word = st_ctrl;
			ST_OFF_STAT:    st_word = st_stat;
			ST_OFF_FIFO:    st_word = fifo_head;
			ST_OFF_FSTAT:   st_word = fifo_stat;
			ST_OFF_RCNT:    st_word = rcnt;
			ST_OFF_SS_CMD:  st_word = ss_cmd;
			ST_OFF_SS_DATA: st_word = ss_data;
			ST_OFF_SS_CTRL: st_word = ss_ctrl;
			ST_OFF_CR1, ST_OFF_CR2, ST_OFF_CR3, ST_OFF_CR4:
				st_word = cr[st_addr[2:1]];
			// Responses read back too
			ST_OFF_RESP1, ST_OFF_RESP2, ST_OFF_RESP3, ST_OFF_RESP4:
				st_word = resp[st_addr[2:1]];
			ST_OFF_HIRQ:    st_word = hirq;
			ST_OFF_MASK:    st_word = hirq_mask;
			default:        st_word = 16'hffff;
		endcase
	end

	////////////////////
	// Console view
	////////////////////
	always_comb
	begin
		ss_word = 16'h0000;
		if (ss_rgn == SS_RGN_REG)
		begin
			// Half-word decode first, it sits inside word 0
			if (ss_hoff == SS_REG_ID)
				ss_word = ST_ID_WORD;
			else if (ss_hoff == SS_REG_VER)
				ss_word = ST_VER_WORD;
			else
				case (ss_woff)
					SS_REG_CTRL:  ss_word = ss_ctrl;
					SS_REG_FSTAT: ss_word = fifo_stat;
					SS_REG_CMD:   ss_word = ss_cmd;
					SS_REG_DATA:  ss_word = ss_data;
					SS_REG_FIFO:  ss_word = byte_swap(fifo_head);
					default:      ss_word = 16'h0000;
				endcase
		end
		else if (ss_rgn == SS_RGN_CDC)
		begin
			case (ss_woff)
				SS_CDC_FIFO: ss_word = byte_swap(fifo_head);
				SS_CDC_HIRQ: ss_word = hirq;
				SS_CDC_MASK: ss_word = hirq_mask;
				// Console reads responses where it wrote CRs
				SS_CDC_CR1, SS_CDC_CR2, SS_CDC_CR3, SS_CDC_CR4:
					ss_word = resp[ss_cr_off[1:0]];
				default:     ss_word = 16'h0000;
			endcase
		end
	end

	always_ff @(posedge mclk or posedge ST_ALE)
	begin
		if (ST_ALE)
		begin
			st_rvalid <= 1'b0;
			ss_rvalid <= 1'b0;
		end
		else
		begin
			st_rvalid <= st_rd;
			ss_rvalid <= ss_rd;
		end
	end

	// Data holds until the next read on that side
	always_ff @(posedge mclk)
	begin
		if (st_rd)
			st_rdata <= st_word;
		if (ss_rd)
			ss_rdata <= ss_word;
	end

endmodule

//--- source/ss_bridge_top.sv
////////////////////
// Both ports arrive synchronous to mclk as one-cycle strobes
////////////////////
module ss_bridge_top #(
	parameter int FIFO_AW = 6
) (
	input  logic        mclk,
	input  logic        ST_ALE,
	input  logic        st_req,
	input  logic        st_we,
	input  logic [7:0]  st_addr,
	input  logic [15:0] st_wdata,
	output logic [15:0] st_rdata,
	output logic        st_rvalid,
	output logic        st_irq,
	input  logic        ss_req,
	input  logic        ss_we,
	input  logic        ss_cs2,
	input  logic [14:1] ss_addr,
	input  logic [15:0] ss_wdata,
	output logic [15:0] ss_rdata,
	output logic        ss_rvalid,
	output logic        ss_irq
);
	import st_map_pkg::*;
	import ss_map_pkg::*;

	// Decoded opcodes
	st_op_e              st_op;
	logic [1:0]          st_idx;
	ss_op_e              ss_op;
	logic [1:0]          ss_idx;
	// Register file
	logic [15:0]         st_ctrl;
	logic [15:0]         st_stat;
	logic [15:0]         ss_ctrl;
	logic [15:0]         ss_cmd;
	logic [15:0]         ss_data;
	logic [15:0]         hirq;
	logic [15:0]         hirq_mask;
	logic [3:0][15:0]    cr;
	logic [3:0][15:0]    resp;
	// FIFO
	logic                fifo_dir;
	logic                fifo_clr;
	logic [15:0]         fifo_head;
	logic [FIFO_AW-1:0]  fifo_usedw;
	logic                fifo_full;
	logic                fifo_empty;
	logic [15:0]         rcnt;

	st_decode st_decode_inst (.*);

	ss_decode ss_decode_inst (.*);

	cdc_regs cdc_regs_inst (.*);

	cdc_fifo #(
		.FIFO_AW (FIFO_AW)
	) cdc_fifo_inst (.*);

	read_mux #(
		.FIFO_AW (FIFO_AW)
	) read_mux_inst (.*);

endmodule

//--- source/ss_decode.sv
////////////////////
// Only the CDC and REG regions decode, ss_cs2 low drops the access
////////////////////
module ss_decode (
	input  logic               ss_req,
	input  logic               ss_we,
	input  logic               ss_cs2,
	input  logic [14:1]        ss_addr,
	output ss_map_pkg::ss_op_e ss_op,
	output logic [1:0]         ss_idx
);
	import ss_map_pkg::*;

	logic       hit;
	logic [2:0] rgn;
	logic [3:0] woff;
	logic       fifo_off;

	assign hit  = ss_req && ss_cs2;
	assign rgn  = ss_addr[14:12];
	assign woff = ss_addr[5:2];

	// FIFO is reachable from both regions
	assign fifo_off = (rgn == SS_RGN_CDC && woff == SS_CDC_FIFO)
		|| (rgn == SS_RGN_REG && woff == SS_REG_FIFO);

	// CR1..CR4 at words 6..9
	assign ss_idx = 2'(woff - SS_CDC_CR1);

	always_comb
	begin
		ss_op = SS_OP_NONE;
		if (hit && !ss_we)
			ss_op = fifo_off ? SS_OP_FIFO_RD : SS_OP_READ;
		else if (hit && fifo_off)
			ss_op = SS_OP_FIFO_WR;
		else if (hit && rgn == SS_RGN_CDC)
		begin
			case (woff)
				SS_CDC_HIRQ:
					ss_op = SS_OP_HIRQ_AND;
				SS_CDC_MASK:
					ss_op = SS_OP_MASK_WR;
				SS_CDC_CR1, SS_CDC_CR2, SS_CDC_CR3, SS_CDC_CR4:
					ss_op = SS_OP_CR_WR;
				default:
					ss_op = SS_OP_NONE;
			endcase
		end
		else if (hit && rgn == SS_RGN_REG)
		begin
			case (woff)
				SS_REG_CTRL:
					ss_op = SS_OP_CTRL_WR;
				SS_REG_CMD:
					ss_op = SS_OP_CMD_WR;
				SS_REG_DATA:
					ss_op = SS_OP_DATA_WR;
				default:
					ss_op = SS_OP_NONE;
			endcase
		end
	end

endmodule

//--- source/st_decode.sv
////////////////////
// One access per st_req cycle, no back-pressure
////////////////////
module st_decode (
	input  logic               st_req,
	input  logic               st_we,
	input  logic [7:0]         st_addr,
	output st_map_pkg::st_op_e st_op,
	output logic [1:0]         st_idx
);
	import st_map_pkg::*;

	// Response slot, 20..26 maps to 0..3
	assign st_idx = st_addr[2:1];

	always_comb
	begin
		st_op = ST_OP_NONE;
		if (st_req && !st_we)
		begin
			// FIFO read pops, every other read is plain
			if (st_addr == ST_OFF_FIFO)
				st_op = ST_OP_FIFO_RD;
			else
				st_op = ST_OP_READ;
		end
		else if (st_req)
		begin
			case (st_addr)
				ST_OFF_CTRL:
					st_op = ST_OP_CTRL_WR;
				ST_OFF_STAT:
					st_op = ST_OP_IRQ_ACK;
				ST_OFF_FIFO:
					st_op = ST_OP_FIFO_WR;
				ST_OFF_RCNT:
					st_op = ST_OP_RCNT_CLR;
				// Any write here clears the console command
				ST_OFF_SS_CMD:
					st_op = ST_OP_CMD_CLR;
				ST_OFF_SS_DATA:
					st_op = ST_OP_DATA_WR;
				ST_OFF_RESP1, ST_OFF_RESP2, ST_OFF_RESP3, ST_OFF_RESP4:
					st_op = ST_OP_RESP_WR;
				ST_OFF_HIRQ:
					st_op = ST_OP_HIRQ_SET;
				ST_OFF_HIRQ_CLR:
					st_op = ST_OP_HIRQ_CLR;
				// Writes to read-only or unmapped offsets drop
				default:
					st_op = ST_OP_NONE;
			endcase
		end
	end

endmodule

//--- test/ss_bridge_checker.sv
////////////////////
// Sampled on mclk and idle while ST_ALE is high
// fail_count rises with each failed assertion
////////////////////
module ss_bridge_checker (
	input logic        mclk,
	input logic        ST_ALE,
	input logic        st_req,
	input logic        st_we,
	input logic [7:0]  st_addr,
	input logic [15:0] st_wdata,
	input logic        st_rvalid,
	input logic        ss_req,
	input logic        ss_irq,
	input logic [15:0] hirq_mask,
	input logic        fifo_dir,
	input logic        fifo_clr,
	input logic        fifo_full,
	input logic        fifo_empty
);
	import st_map_pkg::*;

	int fail_count = 0;

	// Read data comes back exactly one cycle after the request
	st_rvalid_after_read: assert property (@(posedge mclk) disable iff (ST_ALE)
		(st_req && !st_we) |=> st_rvalid)
	else
	begin
		$error("st_rvalid missing one cycle after an st read");
		fail_count++;
	end

	// No rvalid without a read just before it
	st_rvalid_only_after_read: assert property (@(posedge mclk) disable iff (ST_ALE)
		!(st_req && !st_we) |=> !st_rvalid)
	else
	begin
		$error("st_rvalid high without an st read");
		fail_count++;
	end

	// A masked HIRQ bit set from the st side reaches the console
	hirq_set_raises_ss_irq: assert property (@(posedge mclk) disable iff (ST_ALE)
		(st_req && st_we && st_addr == ST_OFF_HIRQ && !ss_req && |(st_wdata & hirq_mask))
		|=> ss_irq)
	else
	begin
		$error("ss_irq low after a masked HIRQ set");
		fail_count++;
	end

	// An accepted st push leaves the FIFO non-empty
	fifo_push_not_empty: assert property (@(posedge mclk) disable iff (ST_ALE)
		(st_req && st_we && st_addr == ST_OFF_FIFO && !fifo_dir && !fifo_clr && !fifo_full)
		|=> !fifo_empty)
	else
	begin
		$error("FIFO empty after an accepted st push");
		fail_count++;
	end

endmodule

bind ss_bridge_top ss_bridge_checker ss_bridge_checker_inst (
	.mclk       (mclk),
	.ST_ALE     (ST_ALE),
	.st_req     (st_req),
	.st_we      (st_we),
	.st_addr    (st_addr),
	.st_wdata   (st_wdata),
	.st_rvalid  (st_rvalid),
	.ss_req     (ss_req),
	.ss_irq     (ss_irq),
	.hirq_mask  (hirq_mask),
	.fifo_dir   (fifo_dir),
	.fifo_clr   (fifo_clr),
	.fifo_full  (fifo_full),
	.fifo_empty (fifo_empty)
);

//--- test/tb_ss_bridge.sv
////////////////////
// Directed tests, the run stops at the first wrong value
// Inputs change on the rising edge, outputs are sampled on the falling edge
////////////////////
module tb_ss_bridge;

	localparam int RESET_CYCLES    = 8;
	// Fewer than 250 accesses, none longer than 8 cycles
	localparam int ACCESS_LIMIT    = 249;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + ACCESS_LIMIT * 8;
	localparam int FIFO_WORDS      = 5;

	// Console regions and byte offsets inside them
	localparam logic [2:0]  RGN_CDC   = 3'b000;
	localparam logic [2:0]  RGN_REG   = 3'b111;
	localparam logic [11:0] CDC_FIFO  = 12'h000;
	localparam logic [11:0] CDC_HIRQ  = 12'h008;
	localparam logic [11:0] CDC_MASK  = 12'h00c;
	localparam logic [11:0] CDC_CR1   = 12'h018;
	localparam logic [11:0] REG_FSTAT = 12'h008;
	localparam logic [11:0] REG_CMD   = 12'h010;
	localparam logic [11:0] REG_FIFO  = 12'h018;

	logic        mclk;
	logic        ST_ALE;
	logic        st_req;
	logic        st_we;
	logic [7:0]  st_addr;
	logic [15:0] st_wdata;
	logic [15:0] st_rdata;
	logic        st_rvalid;
	logic        st_irq;
	logic        ss_req;
	logic        ss_we;
	logic        ss_cs2;
	logic [14:1] ss_addr;
	logic [15:0] ss_wdata;
	logic [15:0] ss_rdata;
	logic        ss_rvalid;
	logic        ss_irq;

	ss_bridge_top ss_bridge_top_inst (.*);

	initial
	begin
		mclk = 1'b0;
		forever #2 mclk = ~mclk;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge mclk);
		abort_run($sformatf("timeout after %0d cycles", WATCHDOG_CYCLES));
	end

	// Bound checker failures end the run at once
	initial
	begin
		wait (ss_bridge_top_inst.ss_bridge_checker_inst.fail_count != 0);
		abort_run("an assertion in the bound checker failed");
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1, "run stopped");
	endtask

	task automatic compare_word(input logic [15:0] got, input logic [15:0] exp,
		input string msg);
		if (got !== exp)
			abort_run($sformatf("mismatch at %0t: %s, got %h expected %h",
				$time, msg, got, exp));
	endtask

	// Region and byte offset to the console address bits 14..1
	function automatic logic [14:1] ss_at(input logic [2:0] rgn, input logic [11:0] boff);
		logic [14:0] byte_addr;
		byte_addr = {rgn, boff};
		return byte_addr[14:1];
	endfunction

	////////////////////
	// Bus accesses
	////////////////////
	task automatic st_write(input logic [7:0] addr, input logic [15:0] data);
		@(posedge mclk);
		st_req   <= 1'b1;
		st_we    <= 1'b1;
		st_addr  <= addr;
		st_wdata <= data;
		@(posedge mclk);
		st_req <= 1'b0;
		@(negedge mclk);
	endtask

	task automatic st_read(input logic [7:0] addr, output logic [15:0] data);
		@(posedge mclk);
		st_req  <= 1'b1;
		st_we   <= 1'b0;
		st_addr <= addr;
		@(posedge mclk);
		st_req <= 1'b0;
		// rvalid belongs to the cycle right after the request
		@(negedge mclk);
		if (!st_rvalid)
			abort_run($sformatf("st read of %h had no rvalid in the next cycle", addr));
		else
			data = st_rdata;
	endtask

	task automatic ss_write(input logic [14:1] addr, input logic [15:0] data);
		@(posedge mclk);
		ss_req   <= 1'b1;
		ss_we    <= 1'b1;
		ss_cs2   <= 1'b1;
		ss_addr  <= addr;
		ss_wdata <= data;
		@(posedge mclk);
		ss_req <= 1'b0;
		ss_cs2 <= 1'b0;
		@(negedge mclk);
	endtask

	task automatic ss_read(input logic [14:1] addr, output logic [15:0] data);
		@(posedge mclk);
		ss_req  <= 1'b1;
		ss_we   <= 1'b0;
		ss_cs2  <= 1'b1;
		ss_addr <= addr;
		@(posedge mclk);
		ss_req <= 1'b0;
		ss_cs2 <= 1'b0;
		@(negedge mclk);
		if (!ss_rvalid)
			abort_run($sformatf("ss read of %h had no rvalid in the next cycle", addr));
		else
			data = ss_rdata;
	endtask

	////////////////////
	// Tests
	////////////////////
	task automatic ident_words();
		logic [15:0] rd;
		st_read(8'h00, rd);
		compare_word(rd, 16'h5253, "st id");
		st_read(8'h02, rd);
		compare_word(rd, 16'h1205, "st version");
		ss_read(ss_at(RGN_REG, 12'h000), rd);
		compare_word(rd, 16'h5253, "ss id");
		ss_read(ss_at(RGN_REG, 12'h002), rd);
		compare_word(rd, 16'h1205, "ss version");
		// Holes in the map
		st_read(8'h40, rd);
		compare_word(rd, 16'hffff, "st unmapped");
		ss_read(ss_at(RGN_CDC, 12'h004), rd);
		compare_word(rd, 16'h0000, "ss unmapped cdc word");
		ss_read(ss_at(3'b010, 12'h000), rd);
		compare_word(rd, 16'h0000, "ss unmapped region");
	endtask

	task automatic command_path();
		logic [15:0] cr_m [4];
		logic [15:0] rd;
		logic [15:0] cmd_w;
		// All three flags enabled
		st_write(8'h04, 16'h0007);
		for (int i = 0; i < 4; i++)
		begin
			cr_m[i] = $urandom;
			ss_write(ss_at(RGN_CDC, CDC_CR1 + 12'(4 * i)), cr_m[i]);
			// Only CR4 raises the cdc flag
			compare_word({15'd0, st_irq}, {15'd0, i == 3}, "st_irq during CR writes");
		end
		st_read(8'h06, rd);
		compare_word(rd & 16'h0007, 16'h0001, "status after CR4");
		for (int i = 0; i < 4; i++)
		begin
			st_read(8'(8'h18 + 2 * i), rd);
			compare_word(rd, cr_m[i], $sformatf("CR%0d at st", i + 1));
		end
		st_write(8'h06, 16'h0001);
		compare_word({15'd0, st_irq}, 16'd0, "st_irq after cdc ack");
		// Console command mailbox
		cmd_w = $urandom;
		ss_write(ss_at(RGN_REG, REG_CMD), cmd_w);
		compare_word({15'd0, st_irq}, 16'd1, "st_irq after cmd write");
		st_read(8'h06, rd);
		compare_word(rd & 16'h0007, 16'h0002, "status after cmd write");
		st_read(8'h10, rd);
		compare_word(rd, cmd_w, "cmd word at st");
		st_write(8'h10, $urandom);
		st_read(8'h10, rd);
		compare_word(rd, 16'h0000, "cmd word after clear");
		st_write(8'h06, 16'h0002);
		compare_word({15'd0, st_irq}, 16'd0, "st_irq after cmd ack");
	endtask

	task automatic compare_hirq_views(input logic [15:0] hirq_m, input logic [15:0] mask_m);
		logic [15:0] rd;
		st_read(8'h28, rd);
		compare_word(rd, hirq_m, "hirq at st");
		st_read(8'h2a, rd);
		compare_word(rd, mask_m, "mask at st");
		ss_read(ss_at(RGN_CDC, CDC_HIRQ), rd);
		compare_word(rd, hirq_m, "hirq at ss");
		ss_read(ss_at(RGN_CDC, CDC_MASK), rd);
		compare_word(rd, mask_m, "mask at ss");
		compare_word({15'd0, ss_irq}, {15'd0, |(hirq_m & mask_m)}, "ss_irq");
	endtask

	task automatic hirq_updates();
		logic [15:0] hirq_m;
		logic [15:0] mask_m;
		logic [15:0] w;
		hirq_m = 16'h0000;
		mask_m = $urandom;
		ss_write(ss_at(RGN_CDC, CDC_MASK), mask_m);
		repeat (3)
		begin
			w = $urandom;
			st_write(8'h28, w);
			hirq_m = hirq_m | w;
			compare_hirq_views(hirq_m, mask_m);
			w = $urandom;
			st_write(8'h2c, w);
			hirq_m = hirq_m & ~w;
			compare_hirq_views(hirq_m, mask_m);
			// Console acks by writing zeros
			w = $urandom;
			ss_write(ss_at(RGN_CDC, CDC_HIRQ), w);
			hirq_m = hirq_m & w;
			compare_hirq_views(hirq_m, mask_m);
		end
		// One bit through the mask and back out
		mask_m = 16'h0010;
		ss_write(ss_at(RGN_CDC, CDC_MASK), mask_m);
		st_write(8'h28, 16'h0010);
		hirq_m = hirq_m | 16'h0010;
		compare_hirq_views(hirq_m, mask_m);
		ss_write(ss_at(RGN_CDC, CDC_HIRQ), 16'hffef);
		hirq_m = hirq_m & 16'hffef;
		compare_hirq_views(hirq_m, mask_m);
	endtask

	task automatic response_words();
		logic [15:0] resp_m [4];
		logic [15:0] rd;
		for (int i = 0; i < 4; i++)
		begin
			resp_m[i] = $urandom;
			st_write(8'(8'h20 + 2 * i), resp_m[i]);
		end
		for (int i = 0; i < 4; i++)
		begin
			ss_read(ss_at(RGN_CDC, CDC_CR1 + 12'(4 * i)), rd);
			compare_word(rd, resp_m[i], $sformatf("response %0d at ss", i + 1));
		end
	endtask

	task automatic fifo_forward();
		logic [15:0] q [$];
		logic [15:0] w;
		logic [15:0] rd;
		int n;
		// Direction 0 with the fifo flag enabled
		st_write(8'h04, 16'h0004);
		st_write(8'h0e, 16'h0000);
		for (int i = 0; i < FIFO_WORDS; i++)
		begin
			w = $urandom;
			q.push_back(w);
			st_write(8'h08, w);
		end
		st_read(8'h0c, rd);
		compare_word(rd, 16'(FIFO_WORDS), "fifo status at st");
		ss_read(ss_at(RGN_REG, REG_FSTAT), rd);
		compare_word(rd, 16'(FIFO_WORDS), "fifo status at ss");
		n = 0;
		while (q.size() > 0)
		begin
			w = q.pop_front();
			// Both console windows onto the FIFO, taken in turn
			if (n % 2 == 0)
				ss_read(ss_at(RGN_CDC, CDC_FIFO), rd);
			else
				ss_read(ss_at(RGN_REG, REG_FIFO), rd);
			compare_word(rd, {w[7:0], w[15:8]}, $sformatf("fifo word %0d at ss", n));
			n++;
		end
		st_read(8'h0e, rd);
		compare_word(rd, 16'(n), "read counter");
		st_read(8'h0c, rd);
		compare_word(rd, 16'h0000, "fifo status after drain");
		st_read(8'h06, rd);
		compare_word(rd & 16'h0007, 16'h0004, "status after drain");
		compare_word({15'd0, st_irq}, 16'd1, "st_irq after drain");
		st_write(8'h06, 16'h0004);
		compare_word({15'd0, st_irq}, 16'd0, "st_irq after fifo ack");
	endtask

	task automatic fifo_reverse();
		logic [15:0] q [$];
		logic [15:0] w;
		logic [15:0] rd;
		// Direction 1, flags off
		st_write(8'h04, 16'h0200);
		for (int i = 0; i < FIFO_WORDS; i++)
		begin
			w = $urandom;
			q.push_back(w);
			ss_write(ss_at(RGN_CDC, CDC_FIFO), w);
		end
		st_read(8'h0c, rd);
		compare_word(rd, 16'(FIFO_WORDS), "fifo status reverse");
		while (q.size() > 0)
		begin
			w = q.pop_front();
			st_read(8'h08, rd);
			compare_word(rd, {w[7:0], w[15:8]}, "fifo word at st");
		end
		// Reset pulse drops what is left
		ss_write(ss_at(RGN_CDC, CDC_FIFO), $urandom);
		ss_write(ss_at(RGN_CDC, CDC_FIFO), $urandom);
		st_read(8'h0c, rd);
		compare_word(rd, 16'h0002, "fifo status before reset pulse");
		st_write(8'h04, 16'h0300);
		st_write(8'h04, 16'h0200);
		st_read(8'h0c, rd);
		compare_word(rd, 16'h0000, "fifo status after reset pulse");
	endtask

	initial
	begin
		void'($urandom(32'hebdfbe39));
		ST_ALE   <= 1'b1;
		st_req   <= 1'b0;
		st_we    <= 1'b0;
		st_addr  <= 8'h00;
		st_wdata <= 16'h0000;
		ss_req   <= 1'b0;
		ss_we    <= 1'b0;
		ss_cs2   <= 1'b0;
		ss_addr  <= '0;
		ss_wdata <= 16'h0000;
		repeat (RESET_CYCLES) @(posedge mclk);
		ST_ALE <= 1'b0;
		@(negedge mclk);
		compare_word({14'd0, st_irq, ss_irq}, 16'd0, "interrupts after reset");
		ident_words();
		command_path();
		hirq_updates();
		response_words();
		fifo_forward();
		fifo_reverse();
		// Let the bound checker see the last accesses
		repeat (2) @(negedge mclk);
		$display("all tests passed");
		$finish;
	end

endmodule
